/* include/status_defs.svh */
// status reporter widths, register address and byte count defines
`ifndef STATUS_DEFS_SVH
`define STATUS_DEFS_SVH

// destination register for every status message
`define STATUS_REG_ADDR 8'h07 // shown on ad whenever no payload byte is out

// width of the parallel status word coming in
`define STATUS_PAYLOAD_BITS 15 // raw status width

// status padded so status + sequence fill whole bytes
`define STATUS_ALIGNED_BITS 18 // 18 + 6 = 24 bits = 3 payload bytes

// message length on the byte bus
`define STATUS_NUM_BYTES 4 // address byte + 3 payload bytes

// sequence number carried in payload byte 0
`define STATUS_SEQ_BITS 6 // upper six bits of byte 0, also low bits of wd

// Payload byte layout after the address byte
//   byte 0 : seq[5:0], status[1:0]
//   byte 1 : status[9:2]
//   byte 2 : 3'b000, status[14:10]
// rq stays high on address, byte 0, byte 1 and drops on byte 2
//
// Command byte written with we
//   wd[7:6] : mode
//   wd[5:0] : sequence number

`endif

/* verilog/status_pkg.sv */
// status reporter types: mode enum, status word, sequence and byte types
`include "status_defs.svh"

package status_pkg;

    // command modes, encoding taken from wd[7:6]
    typedef enum logic [1:0] {
        MODE_OFF       = 2'd0, // no messages generated
        MODE_SINGLE    = 2'd1, // one message per command write
        MODE_AUTO_KEEP = 2'd2, // message on status change, seq unchanged
        MODE_AUTO_INC  = 2'd3  // message on status change, seq +1 per message
    } status_mode_t;

    // raw status word as sampled from the input
    typedef logic [`STATUS_PAYLOAD_BITS-1:0] status_word_t;

    // sequence number inserted into payload byte 0
    typedef logic [`STATUS_SEQ_BITS-1:0] status_seq_t;

    // one byte on the command or address/data bus
    typedef logic [7:0] status_byte_t;

    // Notes on use
    //   mode[1] set means an automatic mode, so
    //   status changes alone trigger messages.
    //   MODE_SINGLE relies only on the pending flag
    //   that is raised by the command write.

endpackage

/* verilog/status_command.sv */
// mode register, sequence counter, pending flag and send request
`timescale 1ns/1ps
`include "status_defs.svh"

module status_command import status_pkg::*; (
    input  logic         rst,            // clock
    input  logic         clk,            // async reset, active high
    input  logic         we,             // command write strobe
    input  status_byte_t wd,             // {mode, seq}
    input  logic         start,          // downstream took the address byte
    input  logic         status_changed, // sticky change flag from sampler
    output logic         send_req,       // message is due
    output status_seq_t  seq             // sequence number for payload byte 0
);

    status_mode_t mode;     // current mode
    status_mode_t wd_mode;  // mode field of the command byte
    status_seq_t  wd_seq;   // seq field of the command byte
    logic         cmd_pend; // command written, message not yet started
    logic         auto_on;  // one of the automatic modes

    assign wd_mode = status_mode_t'(wd[7:6]);
    assign wd_seq  = wd[`STATUS_SEQ_BITS-1:0];
    assign auto_on = (mode == MODE_AUTO_KEEP) || (mode == MODE_AUTO_INC);

    // pending command or an automatic mode that has seen a change
    assign send_req = cmd_pend || (auto_on && status_changed);

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            mode <= MODE_OFF;
        end else if (we) begin
            mode <= wd_mode;           // takes effect on the write edge
        end
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            seq <= '0;
        end else if (we) begin
            seq <= wd_seq;             // write wins over increment
        end else if (start && (mode == MODE_AUTO_INC)) begin
            seq <= seq + status_seq_t'(1); // wraps at 64
        end
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            cmd_pend <= 1'b0;
        end else if (we && (wd_mode != MODE_OFF)) begin
            cmd_pend <= 1'b1;          // any non-off write asks for one message
        end else if (start) begin
            cmd_pend <= 1'b0;          // message accepted downstream
        end
    end

    // sequence number moves only on a command write or an accepted message
    a_seq_change: assert property (
        @(posedge rst) disable iff (clk)
        (seq != $past(seq)) |-> ($past(we) || $past(start))
    ) else $error("sequence number changed without we or start");

endmodule

/* verilog/status_sampler.sv */
// input register, frozen last-sent status and sticky change flag
`timescale 1ns/1ps

module status_sampler import status_pkg::*; (
    input  logic         rst,            // clock
    input  logic         clk,            // async reset, active high
    input  status_word_t status,         // free running, maybe other domain
    input  logic         start,          // message accepted, freeze now
    output status_word_t status_sync,    // status one cycle later
    output logic         status_changed  // differs from last sent value
);

    status_word_t status_sent; // copy of what went out with the last message
    logic         differs;     // registered vs frozen, combinational

    assign differs = (status_sync != status_sent);

    // input register, always on
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            status_sync <= '0;
        end else begin
            status_sync <= status;     // one cycle latency
        end
    end

    // frozen copy, updated with the value that goes into the payload
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            status_sent <= '0;
        end else if (start) begin
            status_sent <= status_sync; // same value the serializer loads
        end
    end

    // sticky flag, a change that reverts before start still counts
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            status_changed <= 1'b0;
        end else if (start) begin
            status_changed <= 1'b0;    // current value is being sent
        end else begin
            status_changed <= status_changed || differs;
        end
    end

    // Timing summary
    //   status      -> status_sync     : 1 cycle
    //   status_sync -> status_changed  : 1 cycle
    //   status_changed -> rq           : 1 cycle (via send_req)
    // so a status change reaches rq three edges after it
    // appears on the input, when an automatic mode is set

endmodule

/* verilog/status_serializer.sv */
// request shift register and payload byte shifter driving rq and ad
`timescale 1ns/1ps
`include "status_defs.svh"

module status_serializer import status_pkg::*; (
    input  logic         rst,         // clock
    input  logic         clk,         // async reset, active high
    input  logic         send_req,    // message due
    input  logic         start,       // address byte accepted
    input  status_seq_t  seq,         // sequence number for byte 0
    input  status_word_t status_sync, // registered status
    output logic         rq,          // request, low on last byte
    output status_byte_t ad           // address or payload byte
);

    localparam int DATA_BITS = (`STATUS_NUM_BYTES - 1) * 8; // payload bytes only

    logic [`STATUS_NUM_BYTES-2:0]  rq_sr;          // one bit per cycle rq stays high
    logic [DATA_BITS-1:0]          data_sr;        // payload, byte 0 in the low byte
    logic [`STATUS_ALIGNED_BITS-1:0] aligned_status; // zero padded status
    logic [DATA_BITS-1:0]          payload;        // assembled at start
    logic [DATA_BITS-1:0]          addr_word;      // idle content of data_sr
    logic                          snd_rest;       // bytes 1 and 2 shifting out

    assign aligned_status = {{(`STATUS_ALIGNED_BITS-`STATUS_PAYLOAD_BITS){1'b0}}, status_sync};

    // status[1:0] share byte 0 with seq, the rest fills bytes 1 and 2
    assign payload = {aligned_status[`STATUS_ALIGNED_BITS-1:2], seq, aligned_status[1:0]};

    assign addr_word = DATA_BITS'(`STATUS_REG_ADDR);

    assign rq = rq_sr[0];

    // top bit gone after start, low bit still set while bytes remain
    assign snd_rest = rq_sr[0] && !rq_sr[`STATUS_NUM_BYTES-2];

    assign ad = data_sr[7:0];

    // request shift register
    //   111 : waiting for start, address showing
    //   011 : byte 0
    //   001 : byte 1
    //   000 : byte 2, rq low
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            rq_sr <= '0;
        end else if (send_req && !rq_sr[0]) begin
            rq_sr <= '1;               // new message, raise rq
        end else if (start || !rq_sr[`STATUS_NUM_BYTES-2]) begin
            rq_sr <= rq_sr >> 1;       // first shift on start, then every cycle
        end
    end

    // byte shifter, address whenever nothing is being sent
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            data_sr <= addr_word;      // ad shows the address out of reset
        end else if (start) begin
            data_sr <= payload;        // status and seq as held at this edge
        end else if (snd_rest) begin
            data_sr <= data_sr >> 8;   // next payload byte
        end else begin
            data_sr <= addr_word;      // back to address after byte 2
        end
    end

    // downstream acknowledges only an active request
    a_start_needs_rq: assert property (
        @(posedge rst) disable iff (clk)
        start |-> rq
    ) else $error("start seen while rq is low");

    // fixed schedule after start: rq on bytes 0 and 1, low on byte 2
    a_rq_schedule: assert property (
        @(posedge rst) disable iff (clk)
        start |=> rq ##1 rq ##1 !rq
    ) else $error("rq held beyond two cycles after start");

endmodule

/* verilog/status_gen_top.sv */
// byte-serial status reporter top connecting command, sampler and serializer
`timescale 1ns/1ps

module status_gen_top import status_pkg::*; (
    input  logic         rst,    // clock
    input  logic         clk,    // async reset, active high
    input  logic         we,     // command strobe
    input  status_byte_t wd,     // command byte, mode in [7:6]
    input  status_word_t status, // parallel status, free running
    input  logic         start,  // downstream accepted the address byte
    output status_byte_t ad,     // address / payload byte
    output logic         rq      // request, low on the last byte
);

    status_word_t status_sync;    // registered status
    logic         status_changed; // sticky, cleared on start
    logic         send_req;       // message due
    status_seq_t  seq;            // current sequence number

    status_command u_command (
        .rst            (rst),
        .clk            (clk),
        .we             (we),
        .wd             (wd),
        .start          (start),
        .status_changed (status_changed),
        .send_req       (send_req),
        .seq            (seq)
    );

    status_sampler u_sampler (
        .rst            (rst),
        .clk            (clk),
        .status         (status),
        .start          (start),
        .status_sync    (status_sync),
        .status_changed (status_changed)
    );

    status_serializer u_serializer (
        .rst            (rst),
        .clk            (clk),
        .send_req       (send_req),
        .start          (start),
        .seq            (seq),
        .status_sync    (status_sync),
        .rq             (rq),
        .ad             (ad)
    );

endmodule

/* sim/tb_status_gen.sv */
// testbench for status_gen_top: clock, reset, seeded random stimulus, model, checks, watchdog
`timescale 1ns/1ps
`include "status_defs.svh"

module tb_status_gen import status_pkg::*; ();

    localparam int CLK_HALF_NS    = 4;   // 8 ns period
    localparam int RESET_CYCLES   = 2;
    localparam int N_KEEP_MSGS    = 6;   // status changes in mode 2
    localparam int N_INC_MSGS     = 8;   // status changes in mode 3, enough to wrap
    localparam int N_BP_MSGS      = 4;   // back-pressure messages
    localparam int N_MSGS         = 1 + (1 + N_KEEP_MSGS) + (1 + N_INC_MSGS) + N_BP_MSGS;
    localparam int MARGIN_CYCLES  = 400; // quiet windows, writes, reset
    localparam int TIMEOUT_CYCLES = N_MSGS * 40 + MARGIN_CYCLES;
    localparam int RQ_WAIT_LIMIT  = 10;  // cycles from due message to rq

    logic         rst;    // clock
    logic         clk;    // reset, active high
    logic         we;
    status_byte_t wd;
    status_word_t status;
    logic         start;
    status_byte_t ad;
    logic         rq;

    integer       seed;   // $random state

    // reference model state
    status_mode_t m_mode;
    status_seq_t  m_seq;
    logic         m_pend;    // command written, not yet accepted
    logic         m_changed; // status differed from last sent since last start
    status_word_t m_sent;    // status carried by the last message
    status_word_t m_status;  // status currently driven

    status_gen_top UUT (
        .rst    (rst),
        .clk    (clk),
        .we     (we),
        .wd     (wd),
        .status (status),
        .start  (start),
        .ad     (ad),
        .rq     (rq)
    );

    always #(CLK_HALF_NS) rst = ~rst; // free running clock

    function automatic logic [31:0] next_rand();
        next_rand = $random(seed);
    endfunction

    function automatic status_word_t rand_status();
        logic [31:0] r;
        r = next_rand();
        rand_status = r[`STATUS_PAYLOAD_BITS-1:0];
    endfunction

    function automatic status_seq_t rand_seq();
        logic [31:0] r;
        r = next_rand();
        rand_seq = r[`STATUS_SEQ_BITS-1:0];
    endfunction

    function automatic int rand_range(input int lo, input int span);
        logic [31:0] r;
        r = next_rand();
        rand_range = lo + int'(r[15:0]) % span; // lo .. lo+span-1
    endfunction

    // pending command, or automatic mode with a seen change
    function automatic logic message_due();
        message_due = m_pend ||
                      (((m_mode == MODE_AUTO_KEEP) || (m_mode == MODE_AUTO_INC)) && m_changed);
    endfunction

    task automatic report_mismatch();
        $display("test failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_byte(input status_byte_t got, input status_byte_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s expected %h got %h", $time, what, exp, got);
            report_mismatch();
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s expected %b got %b", $time, what, exp, got);
            report_mismatch();
        end
    endtask

    task automatic check_seq(input status_seq_t got, input status_seq_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s expected %0d got %0d", $time, what, exp, got);
            report_mismatch();
        end
    endtask

    // one-cycle command strobe, the DUT applies it on the second edge
    task automatic write_cmd(input status_mode_t mode_v, input status_seq_t seq_v);
        @(posedge rst);
        we <= 1'b1;
        wd <= {mode_v, seq_v};
        @(posedge rst);          // write edge
        we <= 1'b0;
        m_mode = mode_v;
        m_seq  = seq_v;          // seq loads even in mode off
        if (mode_v != MODE_OFF) begin
            m_pend = 1'b1;
        end
    endtask

    // new status while idle, then three cycles for sync and change flag
    task automatic drive_status(input status_word_t v);
        @(posedge rst);
        status <= v;
        m_status = v;
        if (v != m_sent) begin
            m_changed = 1'b1;    // sticky until the next start
        end
        repeat (3) @(posedge rst);
    endtask

    task automatic wait_rq();
        int n;
        n = 0;
        @(negedge rst);
        while (rq !== 1'b1) begin
            n++;
            if (n > RQ_WAIT_LIMIT) begin
                $display("rq did not rise within %0d cycles of a due message", RQ_WAIT_LIMIT);
                $display("test failed");
                $fatal(1, "no request from DUT");
            end
            @(negedge rst);
        end
    endtask

    task automatic expect_quiet(input int cycles, input string what);
        for (int i = 0; i < cycles; i++) begin
            @(negedge rst);
            check_level(rq, 1'b0, what);
            check_byte(ad, `STATUS_REG_ADDR, "address while idle");
        end
    endtask

    // called at a negedge with rq high, withholds start for delay cycles
    task automatic take_message(input int delay, output status_seq_t sent_seq);
        status_byte_t b0;
        status_byte_t b1;
        status_byte_t b2;
        b0 = {m_seq, m_status[1:0]};          // seq above status[1:0]
        b1 = m_status[9:2];
        b2 = {3'b000, m_status[14:10]};       // zero padded top bits
        check_byte(ad, `STATUS_REG_ADDR, "address when rq rises");
        for (int i = 0; i < delay; i++) begin
            @(negedge rst);
            check_level(rq, 1'b1, "rq while start withheld");
            check_byte(ad, `STATUS_REG_ADDR, "address while start withheld");
        end
        @(posedge rst);
        start <= 1'b1;
        @(posedge rst);                       // edge k, DUT samples start
        start <= 1'b0;
        m_sent    = m_status;
        m_changed = 1'b0;
        m_pend    = 1'b0;
        if (m_mode == MODE_AUTO_INC) begin
            m_seq = m_seq + 6'd1;
        end
        @(negedge rst);
        check_level(rq, 1'b1, "rq on byte 0");
        check_byte(ad, b0, "payload byte 0");
        sent_seq = ad[7:2];
        @(negedge rst);
        check_level(rq, 1'b1, "rq on byte 1");
        check_byte(ad, b1, "payload byte 1");
        @(negedge rst);
        check_level(rq, 1'b0, "rq on byte 2");
        check_byte(ad, b2, "payload byte 2");
        @(negedge rst);
        check_level(rq, message_due(), "rq after last byte");
        check_byte(ad, `STATUS_REG_ADDR, "address after last byte");
    endtask

    task automatic send_message(input int lo, input int span, output status_seq_t sent_seq);
        wait_rq();
        take_message(rand_range(lo, span), sent_seq);
    endtask

    // status change, then either one message or a quiet window as the model says
    task automatic status_step(input int lo, input int span,
                               output logic sent, output status_seq_t sent_seq);
        drive_status(rand_status());
        sent     = message_due();
        sent_seq = '0;
        if (sent) begin
            send_message(lo, span, sent_seq);
        end else begin
            expect_quiet(8, "rq with no message due");
        end
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLK_HALF_NS * 2);
        $display("timeout: run exceeded %0d clock cycles", TIMEOUT_CYCLES);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        status_seq_t keep_seq;
        status_seq_t exp_seq;
        status_seq_t got_seq;
        status_seq_t pick;
        logic        sent;
        seed      = 32'hb257;
        rst       = 1'b0;
        clk       = 1'b1;                     // reset from time 0
        we        = 1'b0;
        wd        = '0;
        status    = '0;
        start     = 1'b0;
        m_mode    = MODE_OFF;
        m_seq     = '0;
        m_pend    = 1'b0;
        m_changed = 1'b0;
        m_sent    = '0;
        m_status  = '0;
        repeat (RESET_CYCLES) @(posedge rst);
        clk <= 1'b0;
        @(negedge rst);
        check_level(rq, 1'b0, "rq after reset");
        check_byte(ad, `STATUS_REG_ADDR, "ad after reset");

        // single request, then status changes that must stay silent
        drive_status(rand_status());
        expect_quiet(4, "rq in mode off");
        write_cmd(MODE_SINGLE, rand_seq());
        send_message(0, 8, got_seq);
        expect_quiet(10, "rq after single message");
        for (int i = 0; i < 3; i++) begin
            drive_status(rand_status());
            expect_quiet(8, "rq on status change in mode 1");
        end

        // mode off writes
        for (int i = 0; i < 3; i++) begin
            write_cmd(MODE_OFF, rand_seq());
            drive_status(rand_status());
            expect_quiet(20, "rq in mode off");
        end

        // automatic, fixed sequence number
        keep_seq = rand_seq();
        write_cmd(MODE_AUTO_KEEP, keep_seq);
        send_message(0, 8, got_seq);
        check_seq(got_seq, keep_seq, "seq after mode 2 write");
        for (int i = 0; i < N_KEEP_MSGS; i++) begin
            status_step(0, 8, sent, got_seq);
            if (sent) begin
                check_seq(got_seq, keep_seq, "seq held in mode 2");
            end
        end

        // automatic, incrementing sequence number, starts near 63 to wrap
        pick = rand_seq();
        exp_seq = {4'hf, pick[1:0]};
        write_cmd(MODE_AUTO_INC, exp_seq);
        send_message(0, 8, got_seq);
        check_seq(got_seq, exp_seq, "seq after mode 3 write");
        for (int i = 0; i < N_INC_MSGS; i++) begin
            status_step(0, 8, sent, got_seq);
            if (sent) begin
                exp_seq = exp_seq + 6'd1;
                check_seq(got_seq, exp_seq, "seq step in mode 3");
            end
        end

        // back-pressure, start held off for 8 to 23 cycles
        for (int i = 0; i < N_BP_MSGS; i++) begin
            status_step(8, 16, sent, got_seq);
            if (sent) begin
                exp_seq = exp_seq + 6'd1;
                check_seq(got_seq, exp_seq, "seq under back-pressure");
            end
        end
        expect_quiet(10, "rq at end of run");

        $display("test passed");
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
verilog/status_pkg.sv
verilog/status_command.sv
verilog/status_sampler.sv
verilog/status_serializer.sv
verilog/status_gen_top.sv
sim/tb_status_gen.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the status reporter testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

TOP=tb_status_gen
OBJ_DIR=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

# compile RTL and testbench into one executable
if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        -f flist.f --top-module "$TOP" -Mdir "$OBJ_DIR"; then
    echo "Verilator build failed"
    exit 1
fi

if [ ! -x "./$OBJ_DIR/V$TOP" ]; then
    echo "simulation executable not found"
    exit 1
fi

# run and keep the output in memory only
sim_out=$("./$OBJ_DIR/V$TOP" 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# the testbench prints its result on a line of its own
if printf '%s\n' "$sim_out" | grep -qx "test passed"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
